// ==== Makefile ====
# Verilator build and run for the register-select unit.

VERILATOR ?= verilator
TOP       ?= regSelTb
LOG       ?= sim.log
BUILD     ?= obj_dir

FILELIST := verilog.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := src/regSel_config.svh
DATA     := verification/regSelCases.mem
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) --binary --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD) -o V$(TOP)

run: $(BIN) $(DATA)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== src/isaPkg.sv ====
//==========================================================
// Instruction encoding types: operation kinds, addressing
// modes, EXG opmodes and the two views of a 16-bit opcode.
//==========================================================
`default_nettype none
`include "regSel_config.svh"

package isaPkg;

    typedef enum logic [3:0] {
        OpNop   = 4'd0,
        OpMove  = 4'd1,
        OpMoveA = 4'd2,
        OpAdd   = 4'd3,
        OpSub   = 4'd4,
        OpAddA  = 4'd5,
        OpSubA  = 4'd6,
        OpAddQ  = 4'd7,
        OpSubQ  = 4'd8,
        OpLea   = 4'd9,
        OpExg   = 4'd10
    } opKindT;

    // Effective address mode field, modes 5 to 7 are not decoded here.
    typedef enum logic [2:0] {
        ModeDn      = 3'b000,
        ModeAn      = 3'b001,
        ModeInd     = 3'b010,
        ModePostInc = 3'b011,
        ModePreDec  = 3'b100,
        ModeOther   = 3'b111
    } adrModeT;

    localparam logic [4:0] ExgDataData = 5'b01000; // Dx and Dy.
    localparam logic [4:0] ExgAdrAdr   = 5'b01001; // Ax and Ay.
    localparam logic [4:0] ExgDataAdr  = 5'b10001; // Dx and Ay.

    typedef struct packed {
        logic [3:0]            opcode;
        logic [`REG_IDX_W-1:0] dstReg;
        logic [2:0]            dstMode; // Opmode for ADD/SUB, bit 8 is direction.
        adrModeT               srcMode;
        logic [`REG_IDX_W-1:0] srcReg;
    } generalViewT;

    typedef struct packed {
        logic [3:0]            opcode;
        logic [`REG_IDX_W-1:0] rx;
        logic                  fixedOne; // Always set for EXG.
        logic [4:0]            opmode;
        logic [`REG_IDX_W-1:0] ry;
    } exgViewT;

    typedef union packed {
        generalViewT generalView;
        exgViewT     exgView;
    } instrWordT;

endpackage

`default_nettype wire

// ==== src/readSelect.sv ====
//==========================================================
// Read stage: registers the strobed instruction, decodes
// the read selects and the (An)+ / -(An) requests.
//==========================================================
`default_nettype none

module readSelect (
    input  logic              clk,
    input  logic              arstN,
    input  logic              instrStrobe,
    input  isaPkg::opKindT    instrOp,
    input  isaPkg::instrWordT instrWord,
    input  logic              supervisor,
    output selPkg::drIdxT     arLogicalRd,
    input  selPkg::arIdxT     arPhysRd,
    output selPkg::readSelT   rdOut,
    output logic              rdValid,
    stageIf.src               stage
);
    import isaPkg::*;
    import selPkg::*;

    logic      isAddSub;
    logic      addSubToEa;
    logic      exgDataAdr;
    logic      stepOp;
    drIdxT     drRd1Next;
    drIdxT     drRd2Next;
    logic      incNext;
    logic      decNext;

    logic      validQ;
    logic      incQ;
    logic      decQ;
    arIdxT     arRd1Q;
    drIdxT     drRd1Q;
    drIdxT     drRd2Q;
    opKindT    opQ;
    instrWordT wordQ;
    logic      supQ;

    assign isAddSub   = (instrOp == OpAdd) || (instrOp == OpSub);
    assign addSubToEa = isAddSub && instrWord.generalView.dstMode[2]; // Dn,<ea> form.
    assign exgDataAdr = (instrOp == OpExg) && (instrWord.exgView.opmode == ExgDataAdr);

    // Operations whose source operand may step its address register.
    assign stepOp = instrOp inside {OpMove, OpMoveA, OpAdd, OpSub,
                                    OpAddA, OpSubA, OpAddQ, OpSubQ};

    assign incNext = stepOp && (instrWord.generalView.srcMode == ModePostInc);
    assign decNext = stepOp && (instrWord.generalView.srcMode == ModePreDec);

    assign arLogicalRd = instrWord.generalView.srcReg;

    always_comb begin
        if (exgDataAdr) begin
            drRd1Next = instrWord.exgView.rx; // Data side of EXG.
        end else if (addSubToEa) begin
            drRd1Next = instrWord.generalView.dstReg;
        end else begin
            drRd1Next = instrWord.generalView.srcReg;
        end
        drRd2Next = addSubToEa ? instrWord.generalView.srcReg
                               : instrWord.generalView.dstReg;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
            incQ   <= 1'b0;
            decQ   <= 1'b0;
        end else begin
            validQ <= instrStrobe;
            incQ   <= instrStrobe && incNext;
            decQ   <= instrStrobe && decNext;
        end
    end

    always_ff @(posedge clk) begin
        if (instrStrobe) begin
            arRd1Q <= arPhysRd;
            drRd1Q <= drRd1Next;
            drRd2Q <= drRd2Next;
            opQ    <= instrOp;
            wordQ  <= instrWord;
            supQ   <= supervisor; // Mapping stays with this instruction.
        end
    end

    always_comb begin
        rdOut.arSelRd1 = arRd1Q;
        rdOut.drSelRd1 = drRd1Q;
        rdOut.drSelRd2 = drRd2Q;
        rdOut.arInc    = incQ;
        rdOut.arDec    = decQ;
    end

    assign rdValid          = validQ;
    assign stage.valid      = validQ;
    assign stage.op         = opQ;
    assign stage.word       = wordQ;
    assign stage.supervisor = supQ;

    // A step request only comes with a valid read and never both ways.
    stepExclusive: assert property (@(posedge clk) disable iff (!arstN)
        (incQ || decQ) |-> (validQ && !(incQ && decQ)));

endmodule

`default_nettype wire

// ==== src/regSelConfig.sv ====
//==========================================================
// Supervisor configuration flag and the logical to
// physical address register translation for A7.
//==========================================================
`default_nettype none
`include "regSel_config.svh"

module regSelConfig (
    input  logic          clk,
    input  logic          arstN,
    input  logic          cfgStrobe,
    input  logic          cfgSupervisor,
    input  logic          instrStrobe,
    input  selPkg::drIdxT rdLogical,
    input  selPkg::drIdxT wbLogical1,
    input  selPkg::drIdxT wbLogical2,
    input  logic          sampleSup,
    output selPkg::arIdxT rdPhys,
    output selPkg::arIdxT wbPhys1,
    output selPkg::arIdxT wbPhys2,
    output logic          supervisor
);
    import selPkg::*;

    logic supFlag;

    // A7 picks the stack pointer of the current mode.
    function automatic arIdxT toPhys(input drIdxT logical, input logic sup);
        if (logical == `SP_LOGICAL) begin
            return sup ? `SSP_PHYS : `USP_PHYS;
        end
        return arIdxT'(logical);
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            supFlag <= 1'b1; // Core leaves reset in supervisor mode.
        end else if (cfgStrobe) begin
            supFlag <= cfgSupervisor;
        end
    end

    assign supervisor = supFlag;
    assign rdPhys     = toPhys(rdLogical, supFlag);
    assign wbPhys1    = toPhys(wbLogical1, sampleSup); // Mode of the in-flight item.
    assign wbPhys2    = toPhys(wbLogical2, sampleSup);

    // A mode change racing an instruction would split its mapping.
    cfgVsInstr: assert property (@(posedge clk) disable iff (!arstN)
        !(cfgStrobe && instrStrobe));

endmodule

`default_nettype wire

// ==== src/regSelTop.sv ====
//==========================================================
// Register-select unit top: read stage, write-back stage
// and the supervisor configuration block.
//==========================================================
`default_nettype none

module regSelTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic              instrStrobe,
    input  isaPkg::opKindT    instrOp,
    input  isaPkg::instrWordT instrWord,
    input  logic              cfgStrobe,
    input  logic              cfgSupervisor,
    output logic              rdValid,
    output selPkg::arIdxT     arSelRd1,
    output selPkg::drIdxT     drSelRd1,
    output selPkg::drIdxT     drSelRd2,
    output logic              arInc,
    output logic              arDec,
    output logic              wbValid,
    output selPkg::arIdxT     arSelWr1,
    output logic              arWr1,
    output selPkg::arIdxT     arSelWr2,
    output logic              arWr2,
    output selPkg::drIdxT     drSelWr1,
    output logic              drWr1,
    output selPkg::drIdxT     drSelWr2,
    output logic              drWr2
);
    import selPkg::*;

    drIdxT    arLogicalRd;
    drIdxT    arLogicalWr1;
    drIdxT    arLogicalWr2;
    arIdxT    arPhysRd;
    arIdxT    arPhysWr1;
    arIdxT    arPhysWr2;
    logic     supervisor;
    readSelT  rdSel;
    writeSelT wbSel;

    stageIf stage ();

    regSelConfig uConfig (
        .clk           (clk),
        .arstN         (arstN),
        .cfgStrobe     (cfgStrobe),
        .cfgSupervisor (cfgSupervisor),
        .instrStrobe   (instrStrobe),
        .rdLogical     (arLogicalRd),
        .wbLogical1    (arLogicalWr1),
        .wbLogical2    (arLogicalWr2),
        .sampleSup     (stage.supervisor),
        .rdPhys        (arPhysRd),
        .wbPhys1       (arPhysWr1),
        .wbPhys2       (arPhysWr2),
        .supervisor    (supervisor)
    );

    readSelect uRead (
        .clk         (clk),
        .arstN       (arstN),
        .instrStrobe (instrStrobe),
        .instrOp     (instrOp),
        .instrWord   (instrWord),
        .supervisor  (supervisor),
        .arLogicalRd (arLogicalRd),
        .arPhysRd    (arPhysRd),
        .rdOut       (rdSel),
        .rdValid     (rdValid),
        .stage       (stage.src)
    );

    writebackSelect uWriteback (
        .clk          (clk),
        .arstN        (arstN),
        .stage        (stage.dst),
        .arLogicalWr1 (arLogicalWr1),
        .arLogicalWr2 (arLogicalWr2),
        .arPhysWr1    (arPhysWr1),
        .arPhysWr2    (arPhysWr2),
        .wbOut        (wbSel),
        .wbValid      (wbValid)
    );

    assign arSelRd1 = rdSel.arSelRd1;
    assign drSelRd1 = rdSel.drSelRd1;
    assign drSelRd2 = rdSel.drSelRd2;
    assign arInc    = rdSel.arInc;
    assign arDec    = rdSel.arDec;

    assign arSelWr1 = wbSel.arSelWr1;
    assign arWr1    = wbSel.arWr1;
    assign arSelWr2 = wbSel.arSelWr2;
    assign arWr2    = wbSel.arWr2;
    assign drSelWr1 = wbSel.drSelWr1;
    assign drWr1    = wbSel.drWr1;
    assign drSelWr2 = wbSel.drSelWr2;
    assign drWr2    = wbSel.drWr2;

endmodule

`default_nettype wire

// ==== src/regSel_config.svh ====
//==========================================================
// Build-time sizes for the register-select unit: register
// field widths and the stack-pointer indices.
//==========================================================
`ifndef REGSEL_CONFIG_SVH
`define REGSEL_CONFIG_SVH

// Logical register number as encoded in the opcode.
`define REG_IDX_W 3

// Physical address register index covers A0-A6, USP and SSP.
`define AR_PHYS_W 4

// A7 in the opcode and its two physical homes.
`define SP_LOGICAL 3'd7
`define USP_PHYS   4'd7
`define SSP_PHYS   4'd8

`endif

// ==== src/selPkg.sv ====
//==========================================================
// Register index types and the read and write select
// bundles produced by the two pipeline stages.
//==========================================================
`default_nettype none
`include "regSel_config.svh"

package selPkg;

    typedef logic [`REG_IDX_W-1:0] drIdxT;
    typedef logic [`AR_PHYS_W-1:0] arIdxT;

    typedef struct packed {
        arIdxT arSelRd1;
        drIdxT drSelRd1;
        drIdxT drSelRd2;
        logic  arInc;
        logic  arDec;
    } readSelT;

    typedef struct packed {
        arIdxT arSelWr1;
        logic  arWr1;
        arIdxT arSelWr2;
        logic  arWr2;
        drIdxT drSelWr1;
        logic  drWr1;
        drIdxT drSelWr2;
        logic  drWr2;
    } writeSelT;

endpackage

`default_nettype wire

// ==== src/stageIf.sv ====
//==========================================================
// Pipeline link carrying one instruction from the read
// stage to the write-back stage.
//==========================================================
`default_nettype none

interface stageIf;
    import isaPkg::*;

    logic      valid;      // One cycle per instruction.
    opKindT    op;
    instrWordT word;
    logic      supervisor; // Flag captured with the instruction.

    modport src (
        output valid, op, word, supervisor
    );

    modport dst (
        input valid, op, word, supervisor
    );

endinterface

`default_nettype wire

// ==== src/writebackSelect.sv ====
//==========================================================
// Write-back stage: decodes the write selects and enables
// of the item from the read stage, with the An-over-Dn lock.
//==========================================================
`default_nettype none

module writebackSelect (
    input  logic             clk,
    input  logic             arstN,
    stageIf.dst              stage,
    output selPkg::drIdxT    arLogicalWr1,
    output selPkg::drIdxT    arLogicalWr2,
    input  selPkg::arIdxT    arPhysWr1,
    input  selPkg::arIdxT    arPhysWr2,
    output selPkg::writeSelT wbOut,
    output logic             wbValid
);
    import isaPkg::*;
    import selPkg::*;

    logic  isQuick;
    logic  exgDataData;
    logic  exgAdrAdr;
    logic  exgDataAdr;
    logic  addSubToEa;
    logic  arWr1Next;
    logic  arWr2Next;
    logic  drWr1Next;
    drIdxT drSel1Next;

    logic  validQ;
    logic  arWr1Q;
    logic  arWr2Q;
    logic  drWr1Q;
    logic  drWr2Q;
    arIdxT arSel1Q;
    arIdxT arSel2Q;
    drIdxT drSel1Q;
    drIdxT drSel2Q;

    assign isQuick     = stage.op inside {OpAddQ, OpSubQ};
    assign exgDataData = (stage.op == OpExg) && (stage.word.exgView.opmode == ExgDataData);
    assign exgAdrAdr   = (stage.op == OpExg) && (stage.word.exgView.opmode == ExgAdrAdr);
    assign exgDataAdr  = (stage.op == OpExg) && (stage.word.exgView.opmode == ExgDataAdr);
    assign addSubToEa  = (stage.op inside {OpAdd, OpSub}) && stage.word.generalView.dstMode[2];

    // Quick ops carry their <ea> in bits 5:0.
    assign arWr1Next = (stage.op inside {OpAddA, OpSubA, OpLea, OpMoveA})
                     || (isQuick && stage.word.generalView.srcMode == ModeAn)
                     || exgAdrAdr || exgDataAdr;
    assign arWr2Next = exgAdrAdr;

    assign arLogicalWr1 = (isQuick || exgDataAdr) ? stage.word.generalView.srcReg
                                                  : stage.word.generalView.dstReg;
    assign arLogicalWr2 = stage.word.exgView.ry;

    always_comb begin
        drSel1Next = stage.word.generalView.dstReg;
        if (exgDataAdr) begin
            drWr1Next  = 1'b1;
            drSel1Next = stage.word.exgView.rx;
        end else if (arWr1Next || arWr2Next) begin
            drWr1Next = 1'b0; // Address write locks out the data write.
        end else if (addSubToEa) begin
            drWr1Next = 1'b0; // Result goes to memory.
        end else if (stage.op == OpMove && stage.word.generalView.dstMode != ModeDn) begin
            drWr1Next = 1'b0;
        end else if (stage.op == OpNop) begin
            drWr1Next = 1'b0;
        end else begin
            drWr1Next = 1'b1;
            if (isQuick) begin
                drSel1Next = stage.word.generalView.srcReg; // Dn of ADDQ/SUBQ.
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
            arWr1Q <= 1'b0;
            arWr2Q <= 1'b0;
            drWr1Q <= 1'b0;
            drWr2Q <= 1'b0;
        end else begin
            validQ <= stage.valid;
            arWr1Q <= stage.valid && arWr1Next;
            arWr2Q <= stage.valid && arWr2Next;
            drWr1Q <= stage.valid && drWr1Next;
            drWr2Q <= stage.valid && exgDataData;
        end
    end

    always_ff @(posedge clk) begin
        if (stage.valid) begin
            arSel1Q <= arPhysWr1;
            arSel2Q <= arPhysWr2;
            drSel1Q <= drSel1Next;
            drSel2Q <= stage.word.exgView.ry; // Second data port, EXG only.
        end
    end

    always_comb begin
        wbOut.arSelWr1 = arSel1Q;
        wbOut.arWr1    = arWr1Q;
        wbOut.arSelWr2 = arSel2Q;
        wbOut.arWr2    = arWr2Q;
        wbOut.drSelWr1 = drSel1Q;
        wbOut.drWr1    = drWr1Q;
        wbOut.drSelWr2 = drSel2Q;
        wbOut.drWr2    = drWr2Q;
    end

    assign wbValid = validQ;

    // Both register files written together only by EXG Dx,Ay.
    adrDataLock: assert property (@(posedge clk) disable iff (!arstN)
        (drWr1Q && arWr1Q) |-> $past(exgDataAdr));

endmodule

`default_nettype wire

// ==== verification/regSelCases.mem ====
// cmd(1 instr, 3 instr back-to-back, 2 cfg, F end) op word sup | arRd1 drRd1 drRd2 inc dec
// | arWr1Sel arWr1 arWr2Sel arWr2 drWr1Sel drWr1 drWr2Sel drWr2, one hex nibble per field
1_1_3401_0_1_1_2_0_0_0_0_0_0_2_1_0_0
1_1_381B_0_3_3_4_1_0_0_0_0_0_4_1_0_0
1_1_34A7_0_8_7_2_0_1_0_0_0_0_0_0_0_0
1_2_2E5D_0_5_5_7_1_0_8_1_0_0_0_0_0_0
1_3_DA43_0_3_3_5_0_0_0_0_0_0_5_1_0_0
1_3_D55C_0_4_2_4_1_0_0_0_0_0_0_0_0_0
1_4_9CA1_0_1_1_6_0_1_0_0_0_0_6_1_0_0
1_4_9F10_0_0_7_0_0_0_0_0_0_0_0_0_0_0
1_5_DDC1_0_1_1_6_0_0_6_1_0_0_0_0_0_0
1_6_96DA_0_2_2_3_1_0_3_1_0_0_0_0_0_0
1_7_568F_0_8_7_3_0_0_8_1_0_0_0_0_0_0
1_7_5244_0_4_4_1_0_0_0_0_0_0_4_1_0_0
1_8_518A_0_2_2_0_0_0_2_1_0_0_0_0_0_0
1_8_5500_0_0_0_2_0_0_0_0_0_0_0_1_0_0
1_9_43D3_0_3_3_1_0_0_1_1_0_0_0_0_0_0
1_9_45DC_0_4_4_2_0_0_2_1_0_0_0_0_0_0
1_A_C745_0_5_5_3_0_0_0_0_0_0_3_1_5_1
1_A_C34F_0_8_7_1_0_0_1_1_8_1_0_0_0_0
1_A_C58C_0_4_2_2_0_0_4_1_0_0_2_1_0_0
3_1_381B_0_3_3_4_1_0_0_0_0_0_4_1_0_0
3_7_568F_0_8_7_3_0_0_8_1_0_0_0_0_0_0
3_A_C58C_0_4_2_2_0_0_4_1_0_0_2_1_0_0
1_4_9CA1_0_1_1_6_0_1_0_0_0_0_6_1_0_0
3_2_2E5F_0_8_7_7_1_0_8_1_0_0_0_0_0_0
2_0_0000_0_0_0_0_0_0_0_0_0_0_0_0_0_0
1_2_2E5F_0_7_7_7_1_0_7_1_0_0_0_0_0_0
1_7_568F_0_7_7_3_0_0_7_1_0_0_0_0_0_0
1_A_C34F_0_7_7_1_0_0_1_1_7_1_0_0_0_0
2_0_0000_1_0_0_0_0_0_0_0_0_0_0_0_0_0
1_1_34A7_0_8_7_2_0_1_0_0_0_0_0_0_0_0
F_0_0000_0_0_0_0_0_0_0_0_0_0_0_0_0_0

// ==== verification/regSelTb.sv ====
//==========================================================
// Testbench for the register-select unit: reads the case
// file, drives the DUT with random idle gaps and checks
// the read and write results against queued expectations.
//==========================================================
`default_nettype none

module regSelTb;
    timeunit 1ns;
    timeprecision 100ps;

    import isaPkg::*;
    import selPkg::*;

    localparam int MaxCases    = 64;
    localparam int MaxGap      = 3;
    localparam int ResetCycles = 4;

    logic      clk;
    logic      arstN;
    logic      instrStrobe;
    opKindT    instrOp;
    instrWordT instrWord;
    logic      cfgStrobe;
    logic      cfgSupervisor;

    logic  rdValid;
    arIdxT arSelRd1;
    drIdxT drSelRd1;
    drIdxT drSelRd2;
    logic  arInc;
    logic  arDec;
    logic  wbValid;
    arIdxT arSelWr1;
    logic  arWr1;
    arIdxT arSelWr2;
    logic  arWr2;
    drIdxT drSelWr1;
    logic  drWr1;
    drIdxT drSelWr2;
    logic  drWr2;

    logic [79:0] caseMem [0:MaxCases-1];
    int          numCases;
    int          cycle;
    int          cycleLimit;
    logic [31:0] rngState;

    readSelT  rdExpQ[$];
    int       rdDueQ[$];
    writeSelT wbExpQ[$];
    int       wbDueQ[$];
    readSelT  gotRd;
    writeSelT gotWb;

    tbClock #(.ResetCycles(ResetCycles)) uClock (
        .clk   (clk),
        .arstN (arstN)
    );

    regSelTop UUT (
        .clk           (clk),
        .arstN         (arstN),
        .instrStrobe   (instrStrobe),
        .instrOp       (instrOp),
        .instrWord     (instrWord),
        .cfgStrobe     (cfgStrobe),
        .cfgSupervisor (cfgSupervisor),
        .rdValid       (rdValid),
        .arSelRd1      (arSelRd1),
        .drSelRd1      (drSelRd1),
        .drSelRd2      (drSelRd2),
        .arInc         (arInc),
        .arDec         (arDec),
        .wbValid       (wbValid),
        .arSelWr1      (arSelWr1),
        .arWr1         (arWr1),
        .arSelWr2      (arSelWr2),
        .arWr2         (arWr2),
        .drSelWr1      (drSelWr1),
        .drWr1         (drWr1),
        .drSelWr2      (drSelWr2),
        .drWr2         (drWr2)
    );

    always_comb begin
        gotRd.arSelRd1 = arSelRd1;
        gotRd.drSelRd1 = drSelRd1;
        gotRd.drSelRd2 = drSelRd2;
        gotRd.arInc    = arInc;
        gotRd.arDec    = arDec;
        gotWb.arSelWr1 = arSelWr1;
        gotWb.arWr1    = arWr1;
        gotWb.arSelWr2 = arSelWr2;
        gotWb.arWr2    = arWr2;
        gotWb.drSelWr1 = drSelWr1;
        gotWb.drWr1    = drWr1;
        gotWb.drSelWr2 = drSelWr2;
        gotWb.drWr2    = drWr2;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compareField(input string name, input int unsigned gotVal,
                                input int unsigned expVal);
        if (gotVal != expVal) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, gotVal, expVal);
            failRun("Output mismatch.");
        end
    endtask

    task automatic checkRead(input readSelT got, input readSelT exp);
        compareField("arSelRd1", got.arSelRd1, exp.arSelRd1);
        compareField("drSelRd1", got.drSelRd1, exp.drSelRd1);
        compareField("drSelRd2", got.drSelRd2, exp.drSelRd2);
        compareField("arInc", got.arInc, exp.arInc);
        compareField("arDec", got.arDec, exp.arDec);
    endtask

    // Selects only matter where their enable is set.
    task automatic checkWrite(input writeSelT got, input writeSelT exp);
        compareField("arWr1", got.arWr1, exp.arWr1);
        compareField("arWr2", got.arWr2, exp.arWr2);
        compareField("drWr1", got.drWr1, exp.drWr1);
        compareField("drWr2", got.drWr2, exp.drWr2);
        if (exp.arWr1) compareField("arSelWr1", got.arSelWr1, exp.arSelWr1);
        if (exp.arWr2) compareField("arSelWr2", got.arSelWr2, exp.arSelWr2);
        if (exp.drWr1) compareField("drSelWr1", got.drSelWr1, exp.drSelWr1);
        if (exp.drWr2) compareField("drSelWr2", got.drSelWr2, exp.drSelWr2);
    endtask

    // One nibble per field, see the case file header.
    task automatic applyCase(input logic [79:0] entry);
        readSelT  expRd;
        writeSelT expWb;
        logic [3:0] cmd;
        cmd = entry[79:76];
        if (cmd == 4'h2) begin
            instrStrobe   <= 1'b0;
            cfgStrobe     <= 1'b1;
            cfgSupervisor <= entry[52];
        end else begin
            instrStrobe <= 1'b1;
            cfgStrobe   <= 1'b0;
            instrOp     <= opKindT'(entry[75:72]);
            instrWord   <= instrWordT'(entry[71:56]);
            expRd.arSelRd1 = entry[51:48];
            expRd.drSelRd1 = entry[46:44];
            expRd.drSelRd2 = entry[42:40];
            expRd.arInc    = entry[36];
            expRd.arDec    = entry[32];
            expWb.arSelWr1 = entry[31:28];
            expWb.arWr1    = entry[24];
            expWb.arSelWr2 = entry[23:20];
            expWb.arWr2    = entry[16];
            expWb.drSelWr1 = entry[14:12];
            expWb.drWr1    = entry[8];
            expWb.drSelWr2 = entry[6:4];
            expWb.drWr2    = entry[0];
            rdExpQ.push_back(expRd);
            rdDueQ.push_back(cycle + 2); // Read stage one edge after sampling.
            wbExpQ.push_back(expWb);
            wbDueQ.push_back(cycle + 3);
        end
    endtask

    task automatic driveIdle();
        instrStrobe <= 1'b0;
        cfgStrobe   <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > cycleLimit) begin
            failRun("Timeout: the run went past its cycle limit.");
        end
    end

    // Sampled on the falling edge where all outputs are settled.
    always @(negedge clk) begin
        if (arstN) begin
            if (rdValid) begin
                if (rdExpQ.size() == 0) begin
                    failRun("rdValid went high with no instruction outstanding.");
                end
                if (cycle != rdDueQ[0]) begin
                    failRun("Read results arrived on the wrong cycle.");
                end
                checkRead(gotRd, rdExpQ.pop_front());
                void'(rdDueQ.pop_front());
            end else if (arInc || arDec) begin
                failRun("Step request raised without rdValid.");
            end
            if (wbValid) begin
                if (wbExpQ.size() == 0) begin
                    failRun("wbValid went high with no instruction outstanding.");
                end
                if (cycle != wbDueQ[0]) begin
                    failRun("Write results arrived on the wrong cycle.");
                end
                checkWrite(gotWb, wbExpQ.pop_front());
                void'(wbDueQ.pop_front());
            end else if (arWr1 || arWr2 || drWr1 || drWr2) begin
                failRun("Write enable raised without wbValid.");
            end
        end
    end

    initial begin
        int gap;
        instrStrobe   <= 1'b0;
        instrOp       <= OpNop;
        instrWord     <= '0;
        cfgStrobe     <= 1'b0;
        cfgSupervisor <= 1'b0;
        rngState      = 32'h9e312786;
        numCases      = -1;

        $readmemh("verification/regSelCases.mem", caseMem);
        for (int i = 0; i < MaxCases; i++) begin
            if (numCases < 0 && caseMem[i][79:76] == 4'hF) begin
                numCases = i;
            end
        end
        if (numCases < 0) begin
            failRun("Case file has no end marker.");
        end
        cycleLimit = numCases * (3 + MaxGap) + ResetCycles + 20;

        @(posedge arstN);
        for (int i = 0; i < numCases; i++) begin
            @(posedge clk);
            applyCase(caseMem[i]);
            if (caseMem[i][79:76] == 4'h3) begin
                gap = 0; // Next case follows in the very next cycle.
            end else begin
                rngState = xorshift32(rngState);
                gap      = int'(rngState % (MaxGap + 1));
            end
            repeat (gap) begin
                @(posedge clk);
                driveIdle();
            end
        end
        @(posedge clk);
        driveIdle();

        while (rdExpQ.size() > 0 || wbExpQ.size() > 0) begin
            @(negedge clk);
        end
        repeat (3) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
//==========================================================
// Testbench clock and reset: 10 ns clock, active-low
// asynchronous reset held for the first cycles.
//==========================================================
`default_nettype none

module tbClock #(
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    initial begin
        arstN <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/isaPkg.sv
src/selPkg.sv
src/stageIf.sv
src/regSelConfig.sv
src/readSelect.sv
src/writebackSelect.sv
src/regSelTop.sv
verification/tbClock.sv
verification/regSelTb.sv
